//--- source/systolic_params.svh
// -----------------------------------------------
// array size and fixed-point format macros
// -----------------------------------------------
`ifndef SYSTOLIC_PARAMS_SVH
`define SYSTOLIC_PARAMS_SVH

// mesh is SA_N x SA_N PEs
`define SA_N 3

// west operand in signed q8.8
`define SA_WIDTH_A 16
`define SA_FRAC_A 8

// north operand in signed q8.8
`define SA_WIDTH_B 16
`define SA_FRAC_B 8

// result in signed q8.8
`define SA_WIDTH_OUT 16
`define SA_FRAC_OUT 8

// guard bits above the full product
`define SA_ACC_HEADROOM 4

// skew lanes carry the wider of the two operands
`define SA_WIDTH_LANE ((`SA_WIDTH_A > `SA_WIDTH_B) ? `SA_WIDTH_A : `SA_WIDTH_B)

// fraction bits between product scale and result scale
`define SA_ALIGN_SHIFT (`SA_FRAC_A + `SA_FRAC_B - `SA_FRAC_OUT)

`endif

//--- source/systolic_pkg.sv
// -----------------------------------------------
// operand, accumulator and result types
// lane structs and result matrix struct
// -----------------------------------------------
`include "systolic_params.svh"

package systolic_pkg;

    // scalar formats
    typedef logic signed [`SA_WIDTH_A-1:0] opa_t;
    typedef logic signed [`SA_WIDTH_B-1:0] opb_t;
    typedef logic signed [`SA_WIDTH_A+`SA_WIDTH_B-1:0] prod_t;
    typedef logic signed [`SA_WIDTH_A+`SA_WIDTH_B+`SA_ACC_HEADROOM-1:0] acc_t;
    typedef logic signed [`SA_WIDTH_OUT-1:0] res_t;

    // raw lane word for the skew delay lines
    typedef logic [`SA_WIDTH_LANE-1:0] lane_t;
    typedef lane_t [`SA_N-1:0] lane_vec_t;

    // one west operand per mesh row
    typedef struct packed {
        opa_t [`SA_N-1:0] lane;
    } west_lanes_t;

    // one north operand per mesh column
    typedef struct packed {
        opb_t [`SA_N-1:0] lane;
    } north_lanes_t;

    // elem[row][col]
    typedef struct packed {
        res_t [`SA_N-1:0][`SA_N-1:0] elem;
    } result_mat_t;

endpackage

//--- source/fxp_saturate.sv
// -----------------------------------------------
// rescale by truncation plus signed clamp
// accumulator format down to result format
// -----------------------------------------------
`timescale 1ns/10ps
`include "systolic_params.svh"

module fxp_saturate (
    input  systolic_pkg::acc_t in,
    output systolic_pkg::res_t out
);
    import systolic_pkg::*;

    localparam int ACC_W = $bits(acc_t);

    // clamp limits of the result format
    localparam res_t RES_MAX = {1'b0, {(`SA_WIDTH_OUT-1){1'b1}}};
    localparam res_t RES_MIN = {1'b1, {(`SA_WIDTH_OUT-1){1'b0}}};

    acc_t shifted;
    logic [ACC_W-`SA_WIDTH_OUT:0] top_bits;

    // arithmetic shift drops the extra fraction bits
    // rounds toward negative infinity
    assign shifted = in >>> `SA_ALIGN_SHIFT;

    // sign bit of result plus everything above it
    assign top_bits = shifted[ACC_W-1:`SA_WIDTH_OUT-1];

    always_comb begin
        if (top_bits == '0 || top_bits == '1) begin
            // all copies of the sign, value fits
            out = res_t'(shifted);
        end else if (shifted[ACC_W-1]) begin
            out = RES_MIN;
        end else begin
            out = RES_MAX;
        end
    end

endmodule

//--- source/systolic_pe.sv
// -----------------------------------------------
// processing element
// multiply, aligned accumulate, saturate, forward
// -----------------------------------------------
`timescale 1ns/10ps
`include "systolic_params.svh"

module systolic_pe (
    input  logic               clk,
    input  logic               rst_n,
    input  systolic_pkg::opa_t in_west,
    input  systolic_pkg::opb_t in_north,
    output systolic_pkg::opa_t out_east,
    output systolic_pkg::opb_t out_south,
    output systolic_pkg::res_t result
);
    import systolic_pkg::*;

    prod_t product;
    acc_t  aligned;
    acc_t  sum;
    res_t  sat_value;

    // exact signed product
    assign product = in_west * in_north;

    // own result sign-extended and moved up to product scale
    assign aligned = acc_t'(result) <<< `SA_ALIGN_SHIFT;

    // headroom bits keep the add from wrapping
    assign sum = acc_t'(product) + aligned;

    fxp_saturate sat0 (
        .in  (sum),
        .out (sat_value)
    );

    // operands march one PE per cycle
    // result updates every cycle, zero inputs hold it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_east  <= '0;
            out_south <= '0;
            result    <= '0;
        end else begin
            out_east  <= in_west;
            out_south <= in_north;
            result    <= sat_value;
        end
    end

endmodule

//--- source/lane_skew.sv
// -----------------------------------------------
// triangular skew, lane k delayed k cycles
// -----------------------------------------------
`timescale 1ns/10ps
`include "systolic_params.svh"

module lane_skew (
    input  logic                    clk,
    input  logic                    rst_n,
    input  systolic_pkg::lane_vec_t lanes_in,
    output systolic_pkg::lane_vec_t lanes_out
);
    import systolic_pkg::*;

    for (genvar k = 0; k < `SA_N; k++) begin : g_lane
        if (k == 0) begin : g_pass
            // lane 0 goes straight through
            assign lanes_out[0] = lanes_in[0];
        end else begin : g_dly
            // chain[0] is the first stage, chain[k-1] the last
            lane_t [k-1:0] chain;

            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    chain <= '0;
                end else begin
                    chain[0] <= lanes_in[k];
                    // remaining stages shift up by one
                    for (int s = 1; s < k; s++) begin
                        chain[s] <= chain[s-1];
                    end
                end
            end

            assign lanes_out[k] = chain[k-1];
        end
    end

endmodule

//--- source/systolic_mesh.sv
// -----------------------------------------------
// N x N grid of PEs
// east/south forwarding and result gathering
// -----------------------------------------------
`timescale 1ns/10ps
`include "systolic_params.svh"

module systolic_mesh (
    input  logic                      clk,
    input  logic                      rst_n,
    input  systolic_pkg::west_lanes_t  west_in,
    input  systolic_pkg::north_lanes_t north_in,
    output systolic_pkg::result_mat_t  c_mat
);
    import systolic_pkg::*;

    // forwarding outputs of every PE, [row][col]
    // last column and last row are not read
    opa_t [`SA_N-1:0][`SA_N-1:0] h_fwd;
    opb_t [`SA_N-1:0][`SA_N-1:0] v_fwd;

    for (genvar i = 0; i < `SA_N; i++) begin : pe_row
        for (genvar j = 0; j < `SA_N; j++) begin : pe_col
            opa_t pe_west;
            opb_t pe_north;

            // west side from mesh edge or left neighbour
            if (j == 0) begin : g_west_edge
                assign pe_west = west_in.lane[i];
            end else begin : g_west_fwd
                assign pe_west = h_fwd[i][j-1];
            end

            // north side from mesh edge or upper neighbour
            if (i == 0) begin : g_north_edge
                assign pe_north = north_in.lane[j];
            end else begin : g_north_fwd
                assign pe_north = v_fwd[i-1][j];
            end

            systolic_pe pe0 (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_west   (pe_west),
                .in_north  (pe_north),
                .out_east  (h_fwd[i][j]),
                .out_south (v_fwd[i][j]),
                .result    (c_mat.elem[i][j])
            );
        end
    end

endmodule

//--- source/systolic_top.sv
// -----------------------------------------------
// top level, two skew lines feeding the mesh
// -----------------------------------------------
`timescale 1ns/10ps
`include "systolic_params.svh"

module systolic_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  systolic_pkg::west_lanes_t  a_col,
    input  systolic_pkg::north_lanes_t b_row,
    output systolic_pkg::result_mat_t  c_mat
);
    import systolic_pkg::*;

    lane_vec_t    west_raw;
    lane_vec_t    west_skew;
    lane_vec_t    north_raw;
    lane_vec_t    north_skew;
    west_lanes_t  west_mesh;
    north_lanes_t north_mesh;

    // widen into skew lanes and narrow back out
    // sign extension keeps the round trip exact
    for (genvar k = 0; k < `SA_N; k++) begin : g_cast
        assign west_raw[k]         = lane_t'(a_col.lane[k]);
        assign north_raw[k]        = lane_t'(b_row.lane[k]);
        assign west_mesh.lane[k]   = opa_t'(west_skew[k]);
        assign north_mesh.lane[k]  = opb_t'(north_skew[k]);
    end

    // row i of A enters i cycles late
    lane_skew skew_west (
        .clk       (clk),
        .rst_n     (rst_n),
        .lanes_in  (west_raw),
        .lanes_out (west_skew)
    );

    // column j of B enters j cycles late
    lane_skew skew_north (
        .clk       (clk),
        .rst_n     (rst_n),
        .lanes_in  (north_raw),
        .lanes_out (north_skew)
    );

    systolic_mesh mesh0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .west_in  (west_mesh),
        .north_in (north_mesh),
        .c_mat    (c_mat)
    );

endmodule

//--- dv/systolic_tb.sv
// -----------------------------------------------
// testbench for the systolic matrix engine
// hand-worked table, lfsr cases, step-wise model
// -----------------------------------------------
`timescale 1ns/10ps
`include "systolic_params.svh"

module systolic_tb;
    import systolic_pkg::*;

    localparam int N           = `SA_N;
    localparam int NUM_TABLE   = 4;
    localparam int NUM_RANDOM  = 8;
    localparam int CASE_CYCLES = 4 * N + 12;
    localparam int WATCHDOG_CYCLES = (NUM_TABLE + NUM_RANDOM) * CASE_CYCLES + 50;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // a[row][k] and b[k][col]
    typedef opa_t [N-1:0][N-1:0] amat_t;
    typedef opb_t [N-1:0][N-1:0] bmat_t;

    typedef struct packed {
        amat_t       a;
        bmat_t       b;
        result_mat_t c;
    } case_t;

    logic         clk;
    logic         rst_n;
    west_lanes_t  a_col;
    north_lanes_t b_row;
    result_mat_t  c_mat;

    case_t       cases [NUM_TABLE];
    int          checks = 0;
    int          errors = 0;
    logic [31:0] lfsr_state = 32'h140f_48f3;

    systolic_top dut0 (
        .clk   (clk),
        .rst_n (rst_n),
        .a_col (a_col),
        .b_row (b_row),
        .c_mat (c_mat)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [`SA_WIDTH_OUT-1:0] expected,
                               input logic [`SA_WIDTH_OUT-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_matrix(input result_mat_t expected);
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                check_value($sformatf("c_mat[%0d][%0d]", i, j),
                            expected.elem[i][j], c_mat.elem[i][j]);
            end
        end
    endtask

    // galois lfsr, one step per output bit
    function automatic logic [31:0] take_bits(input int nbits);
        logic [31:0] value;
        logic        out_bit;
        value = '0;
        for (int n = 0; n < nbits; n++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) begin
                lfsr_state = lfsr_state ^ LFSR_TAPS;
            end
            value = {value[30:0], out_bit};
        end
        return value;
    endfunction

    // nbits of noise, sign-extended to 32
    function automatic logic [31:0] rand_operand(input int nbits);
        logic signed [31:0] word;
        word = take_bits(nbits) << (32 - nbits);
        word = word >>> (32 - nbits);
        return word;
    endfunction

    // reference: align, add, floor shift, clamp, one k at a time
    function automatic result_mat_t model_product(input amat_t a, input bmat_t b);
        result_mat_t c;
        longint      acc;
        longint      prod;
        longint      sum;
        longint      res_max;
        longint      res_min;
        res_max = (longint'(1) <<< (`SA_WIDTH_OUT - 1)) - 1;
        res_min = -(longint'(1) <<< (`SA_WIDTH_OUT - 1));
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                acc = 0;
                for (int k = 0; k < N; k++) begin
                    prod = longint'($signed(a[i][k])) * longint'($signed(b[k][j]));
                    sum  = ((acc <<< `SA_ALIGN_SHIFT) + prod) >>> `SA_ALIGN_SHIFT;
                    if (sum > res_max) begin
                        acc = res_max;
                    end else if (sum < res_min) begin
                        acc = res_min;
                    end else begin
                        acc = sum;
                    end
                end
                c.elem[i][j] = acc[`SA_WIDTH_OUT-1:0];
            end
        end
        return c;
    endfunction

    // reset, feed N columns/rows, wait for the wavefront, check twice
    task automatic run_case(input amat_t a, input bmat_t b, input result_mat_t expected);
        @(negedge clk);
        rst_n = 1'b0;
        a_col = '0;
        b_row = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        // nothing left over from an earlier case
        check_matrix('0);
        for (int k = 0; k < N; k++) begin
            for (int m = 0; m < N; m++) begin
                a_col.lane[m] = a[m][k];
                b_row.lane[m] = b[k][m];
            end
            @(negedge clk);
        end
        a_col = '0;
        b_row = '0;
        // last term reaches pe(N-1,N-1) at edge 3N-3
        repeat (3 * N) @(negedge clk);
        check_matrix(expected);
        // zero inputs must hold the result
        repeat (2) @(negedge clk);
        check_matrix(expected);
    endtask

    // element order in each constant: [2][2] first down to [0][0]
    task automatic load_table();
        // all zero
        cases[0] = '0;
        // identity times b, negatives and extremes pass unchanged
        cases[1].a = 144'h0100_0000_0000_0000_0100_0000_0000_0000_0100;
        cases[1].b = 144'h0000_EDCC_1234_FFFF_0001_8000_7FFF_FF40_0180;
        cases[1].c = 144'h0000_EDCC_1234_FFFF_0001_8000_7FFF_FF40_0180;
        // sub-lsb products, floor at every step
        cases[2].a = 144'h0003_0003_0003_FFFF_FFFF_FFFF_0001_0001_0001;
        cases[2].b = 144'h0080_0080_0080_0080_0080_0080_0080_0080_0080;
        cases[2].c = 144'h0003_0003_0003_FFFD_FFFD_FFFD_0000_0000_0000;
        // clamp at both ends, later terms start from the clamp
        cases[3].a = 144'h0100_4000_4000_7FFF_8000_8000_8000_7FFF_7FFF;
        cases[3].b = 144'hFF00_0100_0100_FF00_0100_0100_FF00_0100_0100;
        cases[3].c = 144'h8000_7FFF_7FFF_0000_FFFF_FFFF_0000_FFFF_FFFF;
    endtask

    initial begin : main
        amat_t a_rnd;
        bmat_t b_rnd;
        int    nbits;
        rst_n = 1'b0;
        a_col = '0;
        b_row = '0;
        load_table();
        for (int t = 0; t < NUM_TABLE; t++) begin
            run_case(cases[t].a, cases[t].b, cases[t].c);
        end
        // alternate small operands and full-range ones
        for (int r = 0; r < NUM_RANDOM; r++) begin
            nbits = (r % 2 == 0) ? 11 : `SA_WIDTH_A;
            for (int i = 0; i < N; i++) begin
                for (int k = 0; k < N; k++) begin
                    a_rnd[i][k] = opa_t'(rand_operand(nbits));
                    b_rnd[k][i] = opb_t'(rand_operand(nbits));
                end
            end
            run_case(a_rnd, b_rnd, model_product(a_rnd, b_rnd));
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- all.f
+incdir+source
source/systolic_pkg.sv
source/fxp_saturate.sv
source/systolic_pe.sv
source/lane_skew.sv
source/systolic_mesh.sv
source/systolic_top.sv
dv/systolic_tb.sv

//--- Bender.yml
package:
  name: systolic_array

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/systolic_pkg.sv
      - source/fxp_saturate.sv
      - source/systolic_pe.sv
      - source/lane_skew.sv
      - source/systolic_mesh.sv
      - source/systolic_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - dv/systolic_tb.sv
